// ==== common/avalon_axi_pkg.sv ====
// Widths are fixed here because the packed structs need constant sizes, and only single-word accesses exist.
package avalon_axi_pkg;

    // Byte address width on both buses.
    localparam int ADDRESS_WIDTH = 16;

    // One word is four bytes, so byteenable and wstrb are four bits wide.
    localparam int DATA_BYTES = 4;
    localparam int DATA_WIDTH = 8 * DATA_BYTES;

    // Operation carried by a buffered command.
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cmd_op_e;

    // Response code.
    // The values follow the AXI BRESP and RRESP encoding, so the Avalon
    // response port can reuse them without translation.
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00, // Normal access success.
        RESP_EXOKAY = 2'b01, // Exclusive access success, never produced by AXI4-Lite slaves.
        RESP_SLVERR = 2'b10, // Slave reported an error.
        RESP_DECERR = 2'b11  // No slave at this address.
    } resp_e;

    // One accepted Avalon command as it sits in the buffer.
    typedef struct packed {
        cmd_op_e                 op;         // Read or write.
        logic [ADDRESS_WIDTH-1:0] address;   // Byte address of the word.
        logic [DATA_BYTES-1:0]   byteenable; // Byte lanes to write.
        logic [DATA_WIDTH-1:0]   writedata;  // Ignored for reads.
    } avalon_cmd_t;

    // Response fields returned to the Avalon master.
    // Exactly one of the two valid bits pulses per completed command.
    typedef struct packed {
        logic                  readdatavalid;      // Read data and response are valid.
        logic                  writeresponsevalid; // Write response is valid.
        logic [DATA_WIDTH-1:0] readdata;           // Zero after a write.
        resp_e                 response;           // Code from BRESP or RRESP.
    } avalon_rsp_t;

endpackage

// ==== hdl/avalon_cmd_buffer.sv ====
// Read and write high together is treated as a write, and the master must hold its command while waitrequest is high.
`timescale 1ns/1ps

module avalon_cmd_buffer #(
    parameter int DEPTH = 2 // Number of commands the FIFO can hold.
) (
    input  logic                                      aclk,
    input  logic                                      rst,
    input  logic                                      read,
    input  logic                                      write,
    input  logic [avalon_axi_pkg::ADDRESS_WIDTH-1:0]  address,
    input  logic [avalon_axi_pkg::DATA_BYTES-1:0]     byteenable,
    input  logic [avalon_axi_pkg::DATA_WIDTH-1:0]     writedata,
    output logic                                      waitrequest,
    output avalon_axi_pkg::avalon_cmd_t               cmd,
    output logic                                      cmd_valid,
    input  logic                                      cmd_pop
);
    // A single-entry FIFO still needs a one-bit pointer.
    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1); // Count runs from 0 to DEPTH.

    avalon_axi_pkg::avalon_cmd_t mem [DEPTH]; // Command storage.
    avalon_axi_pkg::avalon_cmd_t cmd_in;      // Incoming command, packed.
    logic [PTR_WIDTH-1:0]        wr_ptr;
    logic [PTR_WIDTH-1:0]        rd_ptr;
    logic [COUNT_WIDTH-1:0]      count;
    logic                        push;
    logic                        pop;

    // Pointers wrap at DEPTH so that any depth works, not only powers of two.
    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_comb begin
        cmd_in.op         = write ? avalon_axi_pkg::OP_WRITE : avalon_axi_pkg::OP_READ; // Write wins.
        cmd_in.address    = address;
        cmd_in.byteenable = byteenable;
        cmd_in.writedata  = writedata;
    end

    assign waitrequest = (count == COUNT_WIDTH'(DEPTH)); // Stall only when full.
    assign push        = (read || write) && !waitrequest; // Accepted this edge.
    assign cmd_valid   = (count != '0);
    assign pop         = cmd_pop && cmd_valid; // Ignore pops on an empty FIFO.
    assign cmd         = mem[rd_ptr]; // Head is visible the cycle after the push.

    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither leave the level unchanged.
            endcase
        end
    end

    // Storage holds payload only.
    always_ff @(posedge aclk) begin
        if (push) mem[wr_ptr] <= cmd_in;
    end

endmodule

// ==== axi_lite_master/axi_lite_issue.sv ====
// One AXI transaction is outstanding at a time, and prot is always zero (unprivileged, secure, data).
`timescale 1ns/1ps

module axi_lite_issue (
    input  logic                                     aclk,
    input  logic                                     rst,
    input  avalon_axi_pkg::avalon_cmd_t              cmd,
    input  logic                                     cmd_valid,
    output logic                                     cmd_pop,
    input  logic                                     rsp_done,
    output avalon_axi_pkg::cmd_op_e                  issue_op,
    output logic                                     awvalid,
    output logic [avalon_axi_pkg::ADDRESS_WIDTH-1:0] awaddr,
    output logic [2:0]                               awprot,
    input  logic                                     awready,
    output logic                                     wvalid,
    output logic [avalon_axi_pkg::DATA_WIDTH-1:0]    wdata,
    output logic [avalon_axi_pkg::DATA_BYTES-1:0]    wstrb,
    input  logic                                     wready,
    output logic                                     arvalid,
    output logic [avalon_axi_pkg::ADDRESS_WIDTH-1:0] araddr,
    output logic [2:0]                               arprot,
    input  logic                                     arready
);
    typedef enum logic [1:0] {
        ISSUE_IDLE,  // Waiting for a buffered command.
        ISSUE_WRITE, // AW and W still being offered.
        ISSUE_READ,  // AR still being offered.
        ISSUE_WAIT   // Address phase done, waiting for the response stage.
    } issue_state_e;

    issue_state_e                state;
    avalon_axi_pkg::avalon_cmd_t cmd_q; // Command taken from the buffer head.
    logic                        aw_pending;
    logic                        w_pending;

    // AW and W are tracked on their own, so the slave may take either first.
    assign aw_pending = awvalid && !awready;
    assign w_pending  = wvalid && !wready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state   <= ISSUE_IDLE;
            cmd_pop <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
        end else begin
            cmd_pop <= 1'b0; // Pop is a single-cycle pulse.
            case (state)
                ISSUE_IDLE: begin
                    if (cmd_valid) begin
                        cmd_pop <= 1'b1;
                        if (cmd.op == avalon_axi_pkg::OP_WRITE) begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                            state   <= ISSUE_WRITE;
                        end else begin
                            arvalid <= 1'b1;
                            state   <= ISSUE_READ;
                        end
                    end
                end
                ISSUE_WRITE: begin
                    awvalid <= aw_pending; // Drop each valid on its own handshake.
                    wvalid  <= w_pending;
                    if (!aw_pending && !w_pending) state <= ISSUE_WAIT;
                end
                ISSUE_READ: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        state   <= ISSUE_WAIT;
                    end
                end
                default: begin
                    if (rsp_done) state <= ISSUE_IDLE; // B or R has been returned.
                end
            endcase
        end
    end

    // Latched on the same edge as the pop, so the head may change afterwards.
    always_ff @(posedge aclk) begin
        if (state == ISSUE_IDLE && cmd_valid) cmd_q <= cmd;
    end

    assign issue_op = cmd_q.op;
    assign awaddr   = cmd_q.address;
    assign araddr   = cmd_q.address; // Same word address for either direction.
    assign wdata    = cmd_q.writedata;
    assign wstrb    = cmd_q.byteenable;
    assign awprot   = 3'b000;
    assign arprot   = 3'b000;

endmodule

// ==== axi_lite_master/axi_lite_response.sv ====
// Ready is raised only after the slave shows valid, so each response costs one extra cycle.
`timescale 1ns/1ps

module axi_lite_response (
    input  logic                                  aclk,
    input  logic                                  rst,
    input  avalon_axi_pkg::cmd_op_e               issue_op,
    input  logic                                  bvalid,
    input  avalon_axi_pkg::resp_e                 bresp,
    output logic                                  bready,
    input  logic                                  rvalid,
    input  logic [avalon_axi_pkg::DATA_WIDTH-1:0] rdata,
    input  avalon_axi_pkg::resp_e                 rresp,
    output logic                                  rready,
    output avalon_axi_pkg::avalon_rsp_t           rsp,
    output logic                                  rsp_done
);
    logic                                  b_fire;
    logic                                  r_fire;
    logic                                  readdatavalid_q;
    logic                                  writeresponsevalid_q;
    logic [avalon_axi_pkg::DATA_WIDTH-1:0] readdata_q;
    avalon_axi_pkg::resp_e                 response_q;

    assign b_fire = bvalid && bready;
    assign r_fire = rvalid && rready;

    // Ready follows the channel that the issued command uses.
    // It stays low while idle because no beat is pending then, and it
    // drops again right after the transfer.
    always_ff @(posedge aclk) begin
        if (rst) begin
            bready <= 1'b0;
            rready <= 1'b0;
        end else begin
            bready <= (issue_op == avalon_axi_pkg::OP_WRITE) && bvalid && !bready;
            rready <= (issue_op == avalon_axi_pkg::OP_READ) && rvalid && !rready;
        end
    end

    // Valid pulses last exactly one cycle after the transfer.
    always_ff @(posedge aclk) begin
        if (rst) begin
            readdatavalid_q      <= 1'b0;
            writeresponsevalid_q <= 1'b0;
        end else begin
            readdatavalid_q      <= r_fire;
            writeresponsevalid_q <= b_fire;
        end
    end

    always_ff @(posedge aclk) begin
        if (r_fire) begin
            readdata_q <= rdata;
            response_q <= rresp; // Code passes through unchanged.
        end else if (b_fire) begin
            readdata_q <= '0; // Writes return no data.
            response_q <= bresp;
        end
    end

    always_comb begin
        rsp.readdatavalid      = readdatavalid_q;
        rsp.writeresponsevalid = writeresponsevalid_q;
        rsp.readdata           = readdata_q;
        rsp.response           = response_q;
    end

    assign rsp_done = readdatavalid_q || writeresponsevalid_q; // Frees the issue stage.

endmodule

// ==== hdl/avalon_axi_lite_bridge.sv ====
// Word accesses only with one AXI transaction in flight, so responses return in command order.
`timescale 1ns/1ps

module avalon_axi_lite_bridge #(
    parameter int BUFFER_DEPTH = 2 // Commands accepted ahead of the AXI side.
) (
    input  logic                                     aclk,
    input  logic                                     rst,
    // Avalon-MM slave side.
    input  logic                                     read,
    input  logic                                     write,
    input  logic [avalon_axi_pkg::ADDRESS_WIDTH-1:0] address,
    input  logic [avalon_axi_pkg::DATA_BYTES-1:0]    byteenable,
    input  logic [avalon_axi_pkg::DATA_WIDTH-1:0]    writedata,
    output logic                                     waitrequest,
    output avalon_axi_pkg::avalon_rsp_t              rsp,
    // AXI4-Lite master side.
    output logic                                     awvalid,
    output logic [avalon_axi_pkg::ADDRESS_WIDTH-1:0] awaddr,
    output logic [2:0]                               awprot,
    input  logic                                     awready,
    output logic                                     wvalid,
    output logic [avalon_axi_pkg::DATA_WIDTH-1:0]    wdata,
    output logic [avalon_axi_pkg::DATA_BYTES-1:0]    wstrb,
    input  logic                                     wready,
    input  logic                                     bvalid,
    input  avalon_axi_pkg::resp_e                    bresp,
    output logic                                     bready,
    output logic                                     arvalid,
    output logic [avalon_axi_pkg::ADDRESS_WIDTH-1:0] araddr,
    output logic [2:0]                               arprot,
    input  logic                                     arready,
    input  logic                                     rvalid,
    input  logic [avalon_axi_pkg::DATA_WIDTH-1:0]    rdata,
    input  avalon_axi_pkg::resp_e                    rresp,
    output logic                                     rready
);
    avalon_axi_pkg::avalon_cmd_t cmd;       // Buffer head.
    logic                        cmd_valid;
    logic                        cmd_pop;
    avalon_axi_pkg::cmd_op_e     issue_op;  // Channel the response stage waits on.
    logic                        rsp_done;

    avalon_cmd_buffer #(
        .DEPTH(BUFFER_DEPTH)
    ) u_cmd_buffer (
        .aclk, .rst, .read, .write, .address, .byteenable, .writedata,
        .waitrequest, .cmd, .cmd_valid, .cmd_pop
    );

    axi_lite_issue u_issue (
        .aclk, .rst, .cmd, .cmd_valid, .cmd_pop, .rsp_done, .issue_op,
        .awvalid, .awaddr, .awprot, .awready,
        .wvalid, .wdata, .wstrb, .wready,
        .arvalid, .araddr, .arprot, .arready
    );

    axi_lite_response u_response (
        .aclk, .rst, .issue_op,
        .bvalid, .bresp, .bready,
        .rvalid, .rdata, .rresp, .rready,
        .rsp, .rsp_done
    );

endmodule

// ==== verification/axi_lite_mem_model.sv ====
// AXI4-Lite slave of 64 words at 0x0000 to 0x00FF; higher addresses answer SLVERR, and stall only blocks new ready and valid pulses.
`timescale 1ns/1ps

module axi_lite_mem_model (
    input  logic                                     aclk,
    input  logic                                     rst,
    input  logic                                     stall,
    input  logic                                     awvalid,
    input  logic [avalon_axi_pkg::ADDRESS_WIDTH-1:0] awaddr,
    output logic                                     awready,
    input  logic                                     wvalid,
    input  logic [avalon_axi_pkg::DATA_WIDTH-1:0]    wdata,
    input  logic [avalon_axi_pkg::DATA_BYTES-1:0]    wstrb,
    output logic                                     wready,
    output logic                                     bvalid,
    output avalon_axi_pkg::resp_e                    bresp,
    input  logic                                     bready,
    input  logic                                     arvalid,
    input  logic [avalon_axi_pkg::ADDRESS_WIDTH-1:0] araddr,
    output logic                                     arready,
    output logic                                     rvalid,
    output logic [avalon_axi_pkg::DATA_WIDTH-1:0]    rdata,
    output avalon_axi_pkg::resp_e                    rresp,
    input  logic                                     rready
);
    localparam int WORDS = 64;
    localparam logic [avalon_axi_pkg::ADDRESS_WIDTH-1:0] LIMIT = 16'h0100; // First unmapped byte.

    logic [avalon_axi_pkg::DATA_WIDTH-1:0]    mem [WORDS];
    integer                                   seed;
    logic                                     aw_got;    // Write address captured.
    logic                                     w_got;     // Write data captured.
    logic                                     ar_got;    // Read address captured.
    logic [avalon_axi_pkg::ADDRESS_WIDTH-1:0] aw_addr_q;
    logic [avalon_axi_pkg::ADDRESS_WIDTH-1:0] ar_addr_q;
    logic [avalon_axi_pkg::DATA_WIDTH-1:0]    w_data_q;
    logic [avalon_axi_pkg::DATA_BYTES-1:0]    w_strb_q;
    logic [1:0]                               aw_wait;   // Cycles left before each ready or valid.
    logic [1:0]                               w_wait;
    logic [1:0]                               b_wait;
    logic [1:0]                               ar_wait;
    logic [1:0]                               r_wait;

    // Each delay is a fresh draw of 0 to 3 cycles.
    function automatic logic [1:0] pick_delay();
        integer r;
        r = $random(seed);
        return r[1:0];
    endfunction

    // The fill word carries the byte address, so a stray read shows where it came from.
    initial begin
        seed = 32'hff38;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = {16'h5a5a, 8'h00, i[5:0], 2'b00};
        end
    end

    always @(posedge aclk) begin : slave_seq
        int lane;
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            ar_got  <= 1'b0;
            bresp   <= avalon_axi_pkg::RESP_OKAY;
            rresp   <= avalon_axi_pkg::RESP_OKAY;
            rdata   <= '0;
            aw_wait <= pick_delay();
            w_wait  <= pick_delay();
            b_wait  <= pick_delay();
            ar_wait <= pick_delay();
            r_wait  <= pick_delay();
        end else begin
            awready <= 1'b0; // Ready is a one-cycle pulse against a held valid.
            wready  <= 1'b0;
            arready <= 1'b0;
            if (awvalid && awready) begin
                aw_got    <= 1'b1;
                aw_addr_q <= awaddr;
                aw_wait   <= pick_delay();
            end else if (awvalid && !aw_got && !stall) begin
                if (aw_wait == 2'd0) awready <= 1'b1;
                else aw_wait <= aw_wait - 2'd1;
            end
            if (wvalid && wready) begin
                w_got    <= 1'b1;
                w_data_q <= wdata;
                w_strb_q <= wstrb;
                w_wait   <= pick_delay();
            end else if (wvalid && !w_got && !stall) begin
                if (w_wait == 2'd0) wready <= 1'b1;
                else w_wait <= w_wait - 2'd1;
            end
            // The write lands when B is raised, before any later read can be seen.
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_wait <= pick_delay();
            end else if (aw_got && w_got && !bvalid && !stall) begin
                if (b_wait == 2'd0) begin
                    aw_got <= 1'b0;
                    w_got  <= 1'b0;
                    bvalid <= 1'b1;
                    if (aw_addr_q < LIMIT) begin
                        bresp <= avalon_axi_pkg::RESP_OKAY;
                        for (lane = 0; lane < avalon_axi_pkg::DATA_BYTES; lane++) begin
                            if (w_strb_q[lane]) begin
                                mem[aw_addr_q[7:2]][8*lane +: 8] <= w_data_q[8*lane +: 8];
                            end
                        end
                    end else begin
                        bresp <= avalon_axi_pkg::RESP_SLVERR; // Unmapped, memory untouched.
                    end
                end else begin
                    b_wait <= b_wait - 2'd1;
                end
            end
            if (arvalid && arready) begin
                ar_got    <= 1'b1;
                ar_addr_q <= araddr;
                ar_wait   <= pick_delay();
            end else if (arvalid && !ar_got && !stall) begin
                if (ar_wait == 2'd0) arready <= 1'b1;
                else ar_wait <= ar_wait - 2'd1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                r_wait <= pick_delay();
            end else if (ar_got && !rvalid && !stall) begin
                if (r_wait == 2'd0) begin
                    ar_got <= 1'b0;
                    rvalid <= 1'b1;
                    if (ar_addr_q < LIMIT) begin
                        rdata <= mem[ar_addr_q[7:2]];
                        rresp <= avalon_axi_pkg::RESP_OKAY;
                    end else begin
                        rdata <= '0;
                        rresp <= avalon_axi_pkg::RESP_SLVERR;
                    end
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end
        end
    end

endmodule

// ==== verification/tb_avalon_axi_lite_bridge.sv ====
// Run from the project root so the vector file path resolves; the slave is stalled once, halfway through the vectors.
`timescale 1ns/1ps

module tb_avalon_axi_lite_bridge;
    localparam int MAX_VECTORS  = 64;
    localparam int FIELDS       = 6;  // op, address, byteenable, writedata, readdata, response.
    localparam int STALL_CYCLES = 40; // Long enough to fill the buffer several times over.

    // One response the Avalon master is still owed.
    typedef struct packed {
        logic [15:0]                           index;
        logic                                  is_write;
        logic [avalon_axi_pkg::DATA_WIDTH-1:0] readdata;
        avalon_axi_pkg::resp_e                 response;
    } expected_t;

    logic                                     aclk;
    logic                                     rst;
    logic                                     read;
    logic                                     write;
    logic [avalon_axi_pkg::ADDRESS_WIDTH-1:0] address;
    logic [avalon_axi_pkg::DATA_BYTES-1:0]    byteenable;
    logic [avalon_axi_pkg::DATA_WIDTH-1:0]    writedata;
    logic                                     waitrequest;
    avalon_axi_pkg::avalon_rsp_t              rsp;
    logic                                     awvalid;
    logic [avalon_axi_pkg::ADDRESS_WIDTH-1:0] awaddr;
    logic [2:0]                               awprot;
    logic                                     awready;
    logic                                     wvalid;
    logic [avalon_axi_pkg::DATA_WIDTH-1:0]    wdata;
    logic [avalon_axi_pkg::DATA_BYTES-1:0]    wstrb;
    logic                                     wready;
    logic                                     bvalid;
    avalon_axi_pkg::resp_e                    bresp;
    logic                                     bready;
    logic                                     arvalid;
    logic [avalon_axi_pkg::ADDRESS_WIDTH-1:0] araddr;
    logic [2:0]                               arprot;
    logic                                     arready;
    logic                                     rvalid;
    logic [avalon_axi_pkg::DATA_WIDTH-1:0]    rdata;
    avalon_axi_pkg::resp_e                    rresp;
    logic                                     rready;
    logic                                     stall; // Holds the slave off while high.

    logic [31:0] vectors [MAX_VECTORS*FIELDS];
    expected_t   expected_q[$];
    int          num_vectors = 0;
    int          sent = 0;        // Commands handed to the bridge.
    int          responses = 0;   // Valid pulses seen on the Avalon side.
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 100;
    logic        saw_waitrequest = 1'b0;

    avalon_axi_lite_bridge #(
        .BUFFER_DEPTH(2)
    ) uut (.*);

    axi_lite_mem_model mem_model (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // Every cycle counts toward the limit, reset included.
    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d of %0d responses", cycles, responses,
                     num_vectors);
            $display("Responses %0d of %0d, checks %0d, errors %0d", responses, num_vectors,
                     checks, errors + 1);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic expect_low(input string name, input logic value);
        checks++;
        if (value !== 1'b0) begin
            $display("Mismatch %s: expected %h, got %h", name, 1'b0, value);
            errors++;
        end
    endtask

    // Called at a falling edge; returns one falling edge after the command was taken.
    task automatic send_command(input int idx);
        expected_t exp;
        int        base;
        base           = idx * FIELDS;
        write          = vectors[base][0];
        read           = !vectors[base][0];
        address        = vectors[base + 1][avalon_axi_pkg::ADDRESS_WIDTH-1:0];
        byteenable     = vectors[base + 2][avalon_axi_pkg::DATA_BYTES-1:0];
        writedata      = vectors[base + 3];
        exp.index      = idx[15:0];
        exp.is_write   = vectors[base][0];
        exp.readdata   = vectors[base + 4];
        exp.response   = avalon_axi_pkg::resp_e'(vectors[base + 5][1:0]);
        while (waitrequest) begin // Command is held until the buffer has room.
            saw_waitrequest = 1'b1;
            @(negedge aclk);
        end
        expected_q.push_back(exp); // Taken at the coming rising edge.
        sent++;
        @(negedge aclk);
    endtask

    task automatic check_response();
        expected_t exp;
        responses++;
        if (expected_q.size() == 0) begin
            $display("Response at %0t arrived with no command outstanding", $time);
            errors++;
        end else begin
            exp = expected_q.pop_front();
            checks++;
            if (rsp.writeresponsevalid !== exp.is_write) begin
                $display("Mismatch vector %0d writeresponsevalid: expected %h, got %h",
                         exp.index, exp.is_write, rsp.writeresponsevalid);
                errors++;
            end
            if (rsp.readdata !== exp.readdata) begin
                $display("Mismatch vector %0d readdata: expected %h, got %h",
                         exp.index, exp.readdata, rsp.readdata);
                errors++;
            end
            if (rsp.response !== exp.response) begin
                $display("Mismatch vector %0d response: expected %h, got %h",
                         exp.index, exp.response, rsp.response);
                errors++;
            end
        end
    endtask

    // Outputs settle after the rising edge, so the falling edge sees each pulse once.
    always @(negedge aclk) begin
        if (!rst) begin
            if (rsp.readdatavalid && rsp.writeresponsevalid) begin
                $display("Both readdatavalid and writeresponsevalid high at %0t", $time);
                errors++;
            end else if (rsp.readdatavalid || rsp.writeresponsevalid) begin
                check_response();
            end
            // Plain data accesses are unprivileged and secure, so prot stays 000.
            if (awvalid) begin
                checks++;
                if (awprot !== 3'b000) begin
                    $display("Mismatch awprot: expected %h, got %h", 3'b000, awprot);
                    errors++;
                end
            end
            if (arvalid) begin
                checks++;
                if (arprot !== 3'b000) begin
                    $display("Mismatch arprot: expected %h, got %h", 3'b000, arprot);
                    errors++;
                end
            end
        end
    end

    // Holds the slave off once half the commands have been sent.
    initial begin
        wait (num_vectors > 1 && sent == num_vectors / 2);
        @(negedge aclk);
        stall = 1'b1;
        repeat (STALL_CYCLES) @(negedge aclk);
        stall = 1'b0;
    end

    initial begin
        rst        = 1'b1;
        read       = 1'b0;
        write      = 1'b0;
        address    = '0;
        byteenable = '0;
        writedata  = '0;
        stall      = 1'b0;
        for (int i = 0; i < MAX_VECTORS * FIELDS; i++) begin
            vectors[i] = '1; // An all-ones op marks the end of the list.
        end
        $readmemh("verification/bridge_vectors.txt", vectors);
        while (num_vectors < MAX_VECTORS && vectors[num_vectors * FIELDS] != 32'hffff_ffff) begin
            num_vectors++;
        end
        cycle_limit = num_vectors * 40 + 100;
        if (num_vectors == 0) begin
            $display("No vectors were read from verification/bridge_vectors.txt");
            errors++;
        end
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;
        @(negedge aclk);
        expect_low("waitrequest", waitrequest); // Idle state before the first command.
        expect_low("readdatavalid", rsp.readdatavalid);
        expect_low("writeresponsevalid", rsp.writeresponsevalid);
        expect_low("awvalid", awvalid);
        expect_low("wvalid", wvalid);
        expect_low("arvalid", arvalid);
        for (int i = 0; i < num_vectors; i++) begin
            send_command(i);
        end
        read  = 1'b0;
        write = 1'b0;
        while (responses < num_vectors) begin
            @(negedge aclk);
        end
        repeat (20) @(negedge aclk); // Room for a duplicate pulse to show up.
        if (expected_q.size() != 0) begin
            $display("%0d commands never received a response", expected_q.size());
            errors++;
        end
        if (num_vectors > 1 && !saw_waitrequest) begin
            $display("waitrequest never rose while the slave was stalled");
            errors++;
        end
        $display("Responses %0d of %0d, checks %0d, errors %0d", responses, num_vectors,
                 checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== verification/bridge_vectors.txt ====
// op (1 write, 0 read), address, byteenable, writedata, expected readdata, expected response
// Responses are 0 for OKAY and 2 for SLVERR; writes always expect zero readdata.
1 0000 f 11223344 00000000 0
0 0000 f 00000000 11223344 0
1 0004 f a5a5a5a5 00000000 0
1 0004 3 0000beef 00000000 0
0 0004 f 00000000 a5a5beef 0
1 0008 f 01020304 00000000 0
1 0008 c ffee0000 00000000 0
0 0008 f 00000000 ffee0304 0
1 000c f cafef00d 00000000 0
1 000c 5 00990077 00000000 0
0 000c f 00000000 ca99f077 0
1 0100 f deadbeef 00000000 2
0 0100 f 00000000 00000000 2
0 0ffc f 00000000 00000000 2
0 00f0 f 00000000 5a5a00f0 0
0 0000 f 00000000 11223344 0
1 0010 f 10101010 00000000 0
1 0014 f 14141414 00000000 0
1 0018 f 18181818 00000000 0
1 001c f 1c1c1c1c 00000000 0
0 0010 f 00000000 10101010 0
0 0014 f 00000000 14141414 0
0 0018 f 00000000 18181818 0
0 001c f 00000000 1c1c1c1c 0
1 0010 8 77000000 00000000 0
0 0010 f 00000000 77101010 0
1 0200 f 12345678 00000000 2
0 0004 f 00000000 a5a5beef 0
1 00fc f 0badf00d 00000000 0
0 00fc f 00000000 0badf00d 0

// ==== avalon_axi_lite_bridge.f ====
common/avalon_axi_pkg.sv
hdl/avalon_cmd_buffer.sv
axi_lite_master/axi_lite_issue.sv
axi_lite_master/axi_lite_response.sv
hdl/avalon_axi_lite_bridge.sv
verification/axi_lite_mem_model.sv
verification/tb_avalon_axi_lite_bridge.sv

// ==== Bender.yml ====
package:
  name: avalon_axi_lite_bridge

sources:
  # Package first, then the blocks, then the top level.
  - files:
      - common/avalon_axi_pkg.sv
      - hdl/avalon_cmd_buffer.sv
      - axi_lite_master/axi_lite_issue.sv
      - axi_lite_master/axi_lite_response.sv
      - hdl/avalon_axi_lite_bridge.sv

  # Simulation only.
  - target: test
    files:
      - verification/axi_lite_mem_model.sv
      - verification/tb_avalon_axi_lite_bridge.sv
